//--- design/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data path and address width of the core
`define LSU_XLEN 32

// Bytes in one bus word
`define LSU_NBYTES 4

// Byte lane index width, log2 of the byte count
`define LSU_LSB_W 2

// Value held in the reservation address and data after reset
`define LSU_RSV_RST 32'h0000_0000

// SC result codes written to rd
// Zero means the store went out, one means it was dropped
`define LSU_SC_OK   1'b0
`define LSU_SC_FAIL 1'b1

`endif

//--- design/lsu_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

   // Load kind, decoded from funct3 upstream
   typedef enum logic [2:0] {
      LD_NONE = 3'd0,
      LD_LB   = 3'd1,
      LD_LBU  = 3'd2,
      LD_LH   = 3'd3,
      LD_LHU  = 3'd4,
      LD_LW   = 3'd5
   } ld_op_e;

   // Store kind
   typedef enum logic [1:0] {
      ST_NONE = 2'd0,
      ST_SB   = 2'd1,
      ST_SH   = 2'd2,
      ST_SW   = 2'd3
   } st_op_e;

   // A-extension operations
   typedef enum logic [3:0] {
      AMO_NONE = 4'd0,
      AMO_LR   = 4'd1,
      AMO_SC   = 4'd2,
      AMO_SWAP = 4'd3,
      AMO_ADD  = 4'd4,
      AMO_XOR  = 4'd5,
      AMO_AND  = 4'd6,
      AMO_OR   = 4'd7,
      AMO_MIN  = 4'd8,
      AMO_MAX  = 4'd9,
      AMO_MINU = 4'd10,
      AMO_MAXU = 4'd11
   } amo_op_e;

   // Atomic sequencer states
   typedef enum logic [2:0] {
      SEQ_IDLE = 3'd0,
      SEQ_LOAD = 3'd1,
      SEQ_OP   = 3'd2,
      SEQ_ST   = 3'd3,
      SEQ_DONE = 3'd4
   } seq_state_e;

   // Request from the execute stage, at most one op field is active
   typedef struct packed {
      ld_op_e                ld_op;
      st_op_e                st_op;
      amo_op_e               amo_op;
      logic [`LSU_XLEN-1:0]  addr;
      logic [`LSU_XLEN-1:0]  rs2;
   } lsu_req_t;

   // Data bus request, word addressed with byte strobes
   typedef struct packed {
      logic                   ld_req;
      logic                   st_req;
      logic [`LSU_XLEN-1:0]   addr;
      logic [`LSU_XLEN-1:0]   wdata;
      logic [`LSU_NBYTES-1:0] strb;
   } dbus_req_t;

   // Data bus response, rdata valid only with ack
   typedef struct packed {
      logic                  ack;
      logic [`LSU_XLEN-1:0]  rdata;
   } dbus_rsp_t;

   // Response to the core
   typedef struct packed {
      logic                  done;
      logic                  rd_wr;
      logic [`LSU_XLEN-1:0]  rd_data;
   } lsu_rsp_t;

   // One read word seen as byte lanes or halfword lanes
   typedef union packed {
      logic [`LSU_NBYTES-1:0][7:0]       b;
      logic [`LSU_NBYTES/2-1:0][15:0]    h;
   } word_lanes_u;

endpackage

`default_nettype wire

//--- design/mem_lane_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module mem_lane_align (
   input  wire lsu_pkg::ld_op_e         ld_op_i,
   input  wire lsu_pkg::st_op_e         st_op_i,
   input  wire logic [1:0]              addr_lsb_i,
   input  wire lsu_pkg::word_lanes_u    rdata_i,
   input  wire logic [`LSU_XLEN-1:0]    wdata_i,
   output logic [`LSU_XLEN-1:0]         ld_data_o,
   output logic [`LSU_XLEN-1:0]         st_data_o,
   output logic [`LSU_NBYTES-1:0]       st_strb_o
);

   import lsu_pkg::*;

   logic [7:0]  ld_byte;
   logic [15:0] ld_hword;

   // Lane selection through the union views
   assign ld_byte  = rdata_i.b[addr_lsb_i];
   assign ld_hword = rdata_i.h[addr_lsb_i[1]];

   // Load side, sign or zero extension by op
   always_comb begin
      case (ld_op_i)
         LD_LB:   ld_data_o = {{(`LSU_XLEN-8){ld_byte[7]}}, ld_byte};
         LD_LBU:  ld_data_o = {{(`LSU_XLEN-8){1'b0}}, ld_byte};
         LD_LH:   ld_data_o = {{(`LSU_XLEN-16){ld_hword[15]}}, ld_hword};
         LD_LHU:  ld_data_o = {{(`LSU_XLEN-16){1'b0}}, ld_hword};
         LD_LW:   ld_data_o = rdata_i.b;
         default: ld_data_o = '0;
      endcase
   end

   // Store side
   // Low byte or halfword copied to every lane, strobe picks the target
   always_comb begin
      case (st_op_i)
         ST_SB: begin
            st_data_o = {`LSU_NBYTES{wdata_i[7:0]}};
            st_strb_o = `LSU_NBYTES'(1) << addr_lsb_i;
         end
         ST_SH: begin
            st_data_o = {(`LSU_NBYTES/2){wdata_i[15:0]}};
            // Upper or lower halfword pair
            st_strb_o = addr_lsb_i[1] ? `LSU_NBYTES'(4'b1100) : `LSU_NBYTES'(4'b0011);
         end
         ST_SW: begin
            st_data_o = wdata_i;
            st_strb_o = '1;
         end
         default: begin
            // No store, no lanes written
            st_data_o = wdata_i;
            st_strb_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/amo_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module amo_alu (
   input  wire lsu_pkg::amo_op_e        amo_op_i,
   input  wire logic [`LSU_XLEN-1:0]    mem_val_i,
   input  wire logic [`LSU_XLEN-1:0]    rs2_val_i,
   output logic [`LSU_XLEN-1:0]         result_o
);

   import lsu_pkg::*;

   logic lt_signed;
   logic lt_unsigned;

   // Old memory value against rs2
   assign lt_signed   = $signed(mem_val_i) < $signed(rs2_val_i);
   assign lt_unsigned = mem_val_i < rs2_val_i;

   // Value written back to memory
   always_comb begin
      case (amo_op_i)
         AMO_ADD:  result_o = mem_val_i + rs2_val_i;
         AMO_XOR:  result_o = mem_val_i ^ rs2_val_i;
         AMO_AND:  result_o = mem_val_i & rs2_val_i;
         AMO_OR:   result_o = mem_val_i | rs2_val_i;
         // Keep the smaller or larger of the two
         AMO_MIN:  result_o = lt_signed   ? mem_val_i : rs2_val_i;
         AMO_MAX:  result_o = lt_signed   ? rs2_val_i : mem_val_i;
         AMO_MINU: result_o = lt_unsigned ? mem_val_i : rs2_val_i;
         AMO_MAXU: result_o = lt_unsigned ? rs2_val_i : mem_val_i;
         // SWAP, SC and anything else store rs2 as is
         default:  result_o = rs2_val_i;
      endcase
   end

endmodule

`default_nettype wire

//--- design/lr_sc_reservation.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module lr_sc_reservation (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    save_i,
   input  wire logic                    clear_i,
   input  wire logic [`LSU_XLEN-1:0]    addr_i,
   input  wire logic [`LSU_XLEN-1:0]    rdata_i,
   input  wire logic [`LSU_XLEN-1:0]    mem_val_i,
   output logic                         sc_pass_o
);

   logic                  rsv_valid_q;
   logic [`LSU_XLEN-1:0]  rsv_addr_q;
   logic [`LSU_XLEN-1:0]  rsv_data_q;

   // Reservation set by LR, dropped once the SC retires
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsv_valid_q <= 1'b0;
         rsv_addr_q  <= `LSU_RSV_RST;
         rsv_data_q  <= `LSU_RSV_RST;
      end else if (save_i) begin
         rsv_valid_q <= 1'b1;
         rsv_addr_q  <= addr_i;
         rsv_data_q  <= rdata_i;
      end else if (clear_i) begin
         rsv_valid_q <= 1'b0;
      end
   end

   // Same address and the word still holds the value LR saw
   // A store in between that changed the data breaks the pair
   assign sc_pass_o = rsv_valid_q
                    & (rsv_addr_q == addr_i)
                    & (rsv_data_q == mem_val_i);

endmodule

`default_nettype wire

//--- design/amo_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module amo_sequencer (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    req_valid_i,
   input  wire lsu_pkg::lsu_req_t       req_i,
   input  wire logic                    ack_i,
   input  wire logic [`LSU_XLEN-1:0]    rdata_i,
   input  wire logic [`LSU_XLEN-1:0]    ld_data_i,
   input  wire logic [`LSU_XLEN-1:0]    amo_result_i,
   input  wire logic                    sc_pass_i,
   output logic                         ld_req_o,
   output logic                         st_req_o,
   output logic                         word_access_o,
   output logic [`LSU_XLEN-1:0]         wdata_o,
   output logic [`LSU_XLEN-1:0]         mem_val_o,
   output logic                         save_o,
   output logic                         clear_o,
   output lsu_pkg::lsu_rsp_t            rsp_o
);

   import lsu_pkg::*;

   seq_state_e            state_q;
   seq_state_e            state_d;
   logic [`LSU_XLEN-1:0]  mem_q;
   logic                  is_amo;
   logic                  is_lr;
   logic                  is_sc;
   logic                  plain_ld;
   logic                  plain_st;
   lsu_rsp_t              rsp;

   // Op decode
   assign is_amo   = (req_i.amo_op != AMO_NONE);
   assign is_lr    = (req_i.amo_op == AMO_LR);
   assign is_sc    = (req_i.amo_op == AMO_SC);
   assign plain_ld = req_valid_i & (req_i.ld_op != LD_NONE);
   assign plain_st = req_valid_i & (req_i.st_op != ST_NONE);

   // State register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= SEQ_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Old memory word, captured at the read ack
   always_ff @(posedge clk) begin
      if ((state_q == SEQ_LOAD) && ack_i) begin
         mem_q <= rdata_i;
      end
   end

   // Live read data in the ack cycle, the held word after it
   assign mem_val_o = ((state_q == SEQ_LOAD) && ack_i) ? rdata_i : mem_q;

   // Atomics always go out as full words
   assign word_access_o = (state_q != SEQ_IDLE);

   // Next state and outputs
   always_comb begin
      state_d      = state_q;
      ld_req_o     = 1'b0;
      st_req_o     = 1'b0;
      wdata_o      = req_i.rs2;
      save_o       = 1'b0;
      clear_o      = 1'b0;
      rsp.done     = 1'b0;
      rsp.rd_wr    = 1'b0;
      rsp.rd_data  = '0;

      case (state_q)
         SEQ_IDLE: begin
            // Plain accesses pass straight through to the bus
            ld_req_o = plain_ld;
            st_req_o = plain_st;
            if (ack_i && (plain_ld || plain_st)) begin
               rsp.done    = 1'b1;
               rsp.rd_wr   = plain_ld;
               rsp.rd_data = plain_ld ? ld_data_i : '0;
            end
            // Atomic starts its bus read next cycle
            if (req_valid_i && is_amo) begin
               state_d = SEQ_LOAD;
            end
         end

         SEQ_LOAD: begin
            ld_req_o = 1'b1;
            if (ack_i) begin
               save_o  = is_lr;
               state_d = SEQ_OP;
            end
         end

         SEQ_OP: begin
            // LR and a failed SC never write
            if (is_lr || (is_sc && !sc_pass_i)) begin
               state_d = SEQ_DONE;
            end else begin
               state_d = SEQ_ST;
            end
         end

         SEQ_ST: begin
            st_req_o = 1'b1;
            wdata_o  = is_sc ? req_i.rs2 : amo_result_i;
            if (ack_i) begin
               state_d = SEQ_DONE;
            end
         end

         SEQ_DONE: begin
            rsp.done  = 1'b1;
            rsp.rd_wr = 1'b1;
            // SC reports its outcome, the rest return the old word
            if (is_sc) begin
               rsp.rd_data = {{(`LSU_XLEN-1){1'b0}},
                              (sc_pass_i ? `LSU_SC_OK : `LSU_SC_FAIL)};
            end else begin
               rsp.rd_data = mem_q;
            end
            clear_o = is_sc;
            state_d = SEQ_IDLE;
         end

         default: begin
            state_d = SEQ_IDLE;
         end
      endcase
   end

   assign rsp_o = rsp;

endmodule

`default_nettype wire

//--- design/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_top (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                req_valid_i,
   input  wire lsu_pkg::lsu_req_t   req_i,
   input  wire lsu_pkg::dbus_rsp_t  dbus_rsp_i,
   output lsu_pkg::dbus_req_t       dbus_req_o,
   output lsu_pkg::lsu_rsp_t        rsp_o
);

   import lsu_pkg::*;

   // Sequencer side
   logic                    seq_ld_req;
   logic                    seq_st_req;
   logic                    word_access;
   logic [`LSU_XLEN-1:0]    seq_wdata;
   logic [`LSU_XLEN-1:0]    mem_val;
   logic                    rsv_save;
   logic                    rsv_clear;
   logic                    sc_pass;

   // Aligner side
   ld_op_e                  align_ld_op;
   st_op_e                  align_st_op;
   logic [`LSU_XLEN-1:0]    ld_data;
   logic [`LSU_XLEN-1:0]    st_data;
   logic [`LSU_NBYTES-1:0]  st_strb;

   // ALU result
   logic [`LSU_XLEN-1:0]    amo_result;

   // Atomic sequences use word loads and stores
   assign align_ld_op = word_access ? LD_LW : req_i.ld_op;
   assign align_st_op = word_access ? ST_SW : req_i.st_op;

   mem_lane_align u_align (
      .ld_op_i    (align_ld_op),
      .st_op_i    (align_st_op),
      .addr_lsb_i (req_i.addr[`LSU_LSB_W-1:0]),
      .rdata_i    (dbus_rsp_i.rdata),
      .wdata_i    (seq_wdata),
      .ld_data_o  (ld_data),
      .st_data_o  (st_data),
      .st_strb_o  (st_strb)
   );

   amo_alu u_alu (
      .amo_op_i  (req_i.amo_op),
      .mem_val_i (mem_val),
      .rs2_val_i (req_i.rs2),
      .result_o  (amo_result)
   );

   lr_sc_reservation u_rsv (
      .clk       (clk),
      .rst_n     (rst_n),
      .save_i    (rsv_save),
      .clear_i   (rsv_clear),
      .addr_i    (req_i.addr),
      .rdata_i   (dbus_rsp_i.rdata),
      .mem_val_i (mem_val),
      .sc_pass_o (sc_pass)
   );

   amo_sequencer u_seq (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid_i   (req_valid_i),
      .req_i         (req_i),
      .ack_i         (dbus_rsp_i.ack),
      .rdata_i       (dbus_rsp_i.rdata),
      .ld_data_i     (ld_data),
      .amo_result_i  (amo_result),
      .sc_pass_i     (sc_pass),
      .ld_req_o      (seq_ld_req),
      .st_req_o      (seq_st_req),
      .word_access_o (word_access),
      .wdata_o       (seq_wdata),
      .mem_val_o     (mem_val),
      .save_o        (rsv_save),
      .clear_o       (rsv_clear),
      .rsp_o         (rsp_o)
   );

   // Bus request, word address with lane steered data
   assign dbus_req_o.ld_req = seq_ld_req;
   assign dbus_req_o.st_req = seq_st_req;
   assign dbus_req_o.addr   = {req_i.addr[`LSU_XLEN-1:`LSU_LSB_W], {`LSU_LSB_W{1'b0}}};
   assign dbus_req_o.wdata  = st_data;
   assign dbus_req_o.strb   = st_strb;

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_n_o
);

   // Free running clock, starts low
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Reset held for a fixed number of cycles, released on a falling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

//--- tb/lsu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_chk (
   input wire logic                 clk,
   input wire logic                 rst_n,
   input wire logic                 req_valid_i,
   input wire lsu_pkg::dbus_req_t   dbus_req_i,
   input wire logic                 ack_i,
   input wire lsu_pkg::lsu_rsp_t    rsp_i,
   input wire lsu_pkg::seq_state_e  state_i
);

   import lsu_pkg::*;

   // Failed assertions, read by the testbench top at the end of the run
   int unsigned fail_cnt;

   initial fail_cnt = 0;

   // Never a read and a write on the bus at once
   a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
      !(dbus_req_i.ld_req && dbus_req_i.st_req))
      else begin
         fail_cnt++;
         $error("ld_req and st_req high in the same cycle");
      end

   // Pending request keeps its fields until ack
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ((dbus_req_i.ld_req || dbus_req_i.st_req) && !ack_i) |=> $stable(dbus_req_i))
      else begin
         fail_cnt++;
         $error("bus request changed before ack");
      end

   // Quiet outputs while in reset
   a_reset: assert property (@(posedge clk)
      !rst_n |-> (!rsp_i.done && !dbus_req_i.ld_req && !dbus_req_i.st_req))
      else begin
         fail_cnt++;
         $error("done or a bus request high during reset");
      end

   a_done_valid: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_i.done |-> req_valid_i)
      else begin
         fail_cnt++;
         $error("done high without a valid request");
      end

   // OP and DONE are single cycle states
   a_op_len: assert property (@(posedge clk) disable iff (!rst_n)
      (state_i == SEQ_OP) |=> ((state_i == SEQ_ST) || (state_i == SEQ_DONE)))
      else begin
         fail_cnt++;
         $error("OP state lasted more than one cycle");
      end

   a_done_len: assert property (@(posedge clk) disable iff (!rst_n)
      (state_i == SEQ_DONE) |=> (state_i == SEQ_IDLE))
      else begin
         fail_cnt++;
         $error("DONE state lasted more than one cycle");
      end

endmodule

`default_nettype wire

//--- tb/tb_lsu.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu;

   import lsu_pkg::*;

   localparam int NUM_REQS     = 400;
   localparam int DONE_TIMEOUT = 40;
   localparam int RST_TIMEOUT  = 20;

   wire logic    clk;
   wire logic    rst_n;
   logic         req_valid;
   lsu_req_t     req;
   dbus_rsp_t    dbus_rsp;
   dbus_req_t    dbus_req;
   lsu_rsp_t     rsp;

   // Bus side memory and the reference copy
   logic [`LSU_XLEN-1:0] mem [0:15];
   logic [`LSU_XLEN-1:0] model_mem [0:15];

   // Reference reservation
   logic                 rsv_valid;
   logic [`LSU_XLEN-1:0] rsv_addr;
   logic [`LSU_XLEN-1:0] rsv_data;

   // Memory handshake state
   dbus_req_t            bus_seen;
   logic                 bus_busy;
   int unsigned          bus_wait;

   int unsigned          checks;
   int unsigned          errors;
   logic                 timed_out;
   int unsigned          lr_word;

   tb_clk_gen u_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   lsu_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid_i (req_valid),
      .req_i       (req),
      .dbus_rsp_i  (dbus_rsp),
      .dbus_req_o  (dbus_req),
      .rsp_o       (rsp)
   );

   bind lsu_top lsu_chk u_chk (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid_i (req_valid_i),
      .dbus_req_i  (dbus_req_o),
      .ack_i       (dbus_rsp_i.ack),
      .rsp_i       (rsp_o),
      .state_i     (u_seq.state_q)
   );

   // Bus request as it stood before the rising edge
   always @(posedge clk) begin
      bus_seen <= dbus_req;
   end

   // Read or write one word and raise ack
   task automatic serve_access(input dbus_req_t a);
      int unsigned idx;
      idx = a.addr[5:2];
      // Bus address is the request address with the byte offset dropped
      check_value("bus address", {req.addr[`LSU_XLEN-1:2], 2'b00}, a.addr);
      if (a.st_req) begin
         for (int b = 0; b < `LSU_NBYTES; b++) begin
            if (a.strb[b]) begin
               mem[idx][8*b +: 8] = a.wdata[8*b +: 8];
            end
         end
         dbus_rsp.rdata = '0;
      end else begin
         dbus_rsp.rdata = mem[idx];
      end
      dbus_rsp.ack = 1'b1;
   endtask

   // Memory answers on falling edges after 0 to 3 wait cycles
   // Ack lasts one cycle and then drops
   always @(negedge clk) begin
      if (!rst_n) begin
         dbus_rsp = '0;
         bus_busy = 1'b0;
         bus_wait = 0;
      end else if (dbus_rsp.ack) begin
         dbus_rsp = '0;
      end else if (bus_seen.ld_req || bus_seen.st_req) begin
         if (!bus_busy) begin
            bus_busy = 1'b1;
            bus_wait = $urandom_range(3, 0);
         end
         if (bus_wait == 0) begin
            bus_busy = 1'b0;
            serve_access(bus_seen);
         end else begin
            bus_wait--;
         end
      end
   end

   // Load result with the lane chosen by shifting the word
   function automatic logic [`LSU_XLEN-1:0] load_value(input ld_op_e op,
                                                      input logic [`LSU_XLEN-1:0] word,
                                                      input logic [1:0] lsb);
      logic [`LSU_XLEN-1:0] sh;
      sh = word >> (8 * lsb);
      case (op)
         LD_LB:   return {{24{sh[7]}}, sh[7:0]};
         LD_LBU:  return {24'h0, sh[7:0]};
         LD_LH:   return {{16{sh[15]}}, sh[15:0]};
         LD_LHU:  return {16'h0, sh[15:0]};
         default: return word;
      endcase
   endfunction

   // Word after a store with only the addressed bytes replaced
   function automatic logic [`LSU_XLEN-1:0] store_merge(input st_op_e op,
                                                       input logic [`LSU_XLEN-1:0] word,
                                                       input logic [`LSU_XLEN-1:0] data,
                                                       input logic [1:0] lsb);
      logic [`LSU_XLEN-1:0] mask;
      case (op)
         ST_SB:   mask = 32'h0000_00ff << (8 * lsb);
         ST_SH:   mask = 32'h0000_ffff << (8 * lsb);
         default: mask = 32'hffff_ffff;
      endcase
      return (word & ~mask) | ((data << (8 * lsb)) & mask);
   endfunction

   // Value an atomic leaves in memory
   function automatic logic [`LSU_XLEN-1:0] amo_expect(input amo_op_e op,
                                                      input logic [`LSU_XLEN-1:0] old,
                                                      input logic [`LSU_XLEN-1:0] rs2);
      int signed so;
      int signed sr;
      so = old;
      sr = rs2;
      case (op)
         AMO_ADD:  return old + rs2;
         AMO_XOR:  return old ^ rs2;
         AMO_AND:  return old & rs2;
         AMO_OR:   return old | rs2;
         AMO_MIN:  return (so <= sr) ? old : rs2;
         AMO_MAX:  return (so >= sr) ? old : rs2;
         AMO_MINU: return (old <= rs2) ? old : rs2;
         AMO_MAXU: return (old >= rs2) ? old : rs2;
         default:  return rs2;
      endcase
   endfunction

   // Random aligned request biased toward the last LR word
   task automatic make_request(output lsu_req_t r);
      int unsigned kind;
      int unsigned word;
      int unsigned lsb;
      r     = '0;
      kind  = $urandom_range(9, 0);
      word  = $urandom_range(15, 0);
      lsb   = 0;
      r.rs2 = $urandom();
      if (kind <= 2) begin
         r.ld_op = ld_op_e'($urandom_range(5, 1));
      end else if (kind <= 5) begin
         r.st_op = st_op_e'($urandom_range(3, 1));
      end else if (kind == 6) begin
         r.amo_op = AMO_LR;
      end else if (kind == 7) begin
         r.amo_op = AMO_SC;
      end else begin
         r.amo_op = amo_op_e'($urandom_range(11, 3));
      end
      if ((r.amo_op == AMO_SC) && ($urandom_range(3, 0) != 0)) begin
         word = lr_word;
      end
      // Some stores break the reservation
      if ((r.st_op != ST_NONE) && ($urandom_range(2, 0) == 0)) begin
         word = lr_word;
      end
      if (r.amo_op == AMO_LR) begin
         lr_word = word;
      end
      if ((r.ld_op == LD_LB) || (r.ld_op == LD_LBU) || (r.st_op == ST_SB)) begin
         lsb = $urandom_range(3, 0);
      end else if ((r.ld_op == LD_LH) || (r.ld_op == LD_LHU) || (r.st_op == ST_SH)) begin
         lsb = 2 * $urandom_range(1, 0);
      end
      r.addr = word * 4 + lsb;
   endtask

   // Reference model of the memory copy and the reservation
   task automatic predict(input lsu_req_t r, output logic exp_wr,
                          output logic [`LSU_XLEN-1:0] exp_rd);
      int unsigned          idx;
      logic [`LSU_XLEN-1:0] old;
      idx    = r.addr[5:2];
      old    = model_mem[idx];
      exp_wr = 1'b1;
      exp_rd = old;
      if (r.ld_op != LD_NONE) begin
         exp_rd = load_value(r.ld_op, old, r.addr[1:0]);
      end else if (r.st_op != ST_NONE) begin
         exp_wr         = 1'b0;
         exp_rd         = '0;
         model_mem[idx] = store_merge(r.st_op, old, r.rs2, r.addr[1:0]);
      end else if (r.amo_op == AMO_LR) begin
         rsv_valid = 1'b1;
         rsv_addr  = r.addr;
         rsv_data  = old;
      end else if (r.amo_op == AMO_SC) begin
         // SC writes zero to rd on success and one on failure
         if (rsv_valid && (rsv_addr == r.addr) && (rsv_data == old)) begin
            exp_rd         = 32'd0;
            model_mem[idx] = r.rs2;
         end else begin
            exp_rd = 32'd1;
         end
         rsv_valid = 1'b0;
      end else begin
         model_mem[idx] = amo_expect(r.amo_op, old, r.rs2);
      end
   endtask

   task automatic check_value(input string name, input logic [`LSU_XLEN-1:0] exp,
                              input logic [`LSU_XLEN-1:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   // Poll done at each rising edge up to the timeout
   task automatic wait_done(output lsu_rsp_t got, output logic seen);
      int unsigned cycles;
      seen   = 1'b0;
      cycles = 0;
      got    = '0;
      while (!seen && (cycles < DONE_TIMEOUT)) begin
         @(posedge clk);
         cycles++;
         if (rsp.done) begin
            seen = 1'b1;
            got  = rsp;
         end
      end
   endtask

   initial begin
      lsu_req_t             next_req;
      lsu_rsp_t             got;
      logic                 seen;
      logic                 exp_wr;
      logic [`LSU_XLEN-1:0] exp_rd;
      int unsigned          idx;
      int unsigned          cycles;
      int unsigned          gap;
      string                tag;

      void'($urandom(32'h53b));
      req_valid = 1'b0;
      req       = '0;
      dbus_rsp  = '0;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      rsv_valid = 1'b0;
      rsv_addr  = '0;
      rsv_data  = '0;
      lr_word   = 0;
      for (int i = 0; i < 16; i++) begin
         mem[i]       = $urandom();
         model_mem[i] = mem[i];
      end

      cycles = 0;
      while ((rst_n !== 1'b1) && (cycles < RST_TIMEOUT)) begin
         @(posedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was not released within %0d cycles", RST_TIMEOUT);
         timed_out = 1'b1;
      end

      for (int n = 0; (n < NUM_REQS) && !timed_out; n++) begin
         make_request(next_req);
         // Occasional idle cycles between requests
         if ($urandom_range(3, 0) == 0) begin
            gap = $urandom_range(2, 1);
            repeat (gap) begin
               @(negedge clk);
               req_valid = 1'b0;
               req.rs2   = $urandom();
            end
         end
         @(negedge clk);
         req       = next_req;
         req_valid = 1'b1;
         predict(next_req, exp_wr, exp_rd);
         wait_done(got, seen);
         if (!seen) begin
            $display("No done from the DUT within %0d cycles for request %0d",
                     DONE_TIMEOUT, n);
            timed_out = 1'b1;
         end else begin
            idx = next_req.addr[5:2];
            if (next_req.ld_op != LD_NONE) begin
               tag = "load";
            end else if (next_req.st_op != ST_NONE) begin
               tag = "store";
            end else if (next_req.amo_op == AMO_SC) begin
               tag = "sc";
            end else begin
               tag = "amo";
            end
            check_value($sformatf("req %0d %s rd_wr", n, tag), exp_wr, got.rd_wr);
            if (exp_wr) begin
               check_value($sformatf("req %0d %s rd_data", n, tag), exp_rd, got.rd_data);
            end
            check_value($sformatf("req %0d %s memory word %0d", n, tag, idx),
                        model_mem[idx], mem[idx]);
         end
      end

      @(negedge clk);
      req_valid = 1'b0;
      if (!timed_out) begin
         for (int i = 0; i < 16; i++) begin
            check_value($sformatf("final memory word %0d", i), model_mem[i], mem[i]);
         end
      end

      $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
               checks, errors, UUT.u_chk.fail_cnt, timed_out);
      if ((errors == 0) && (UUT.u_chk.fail_cnt == 0) && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/lsu_pkg.sv
design/mem_lane_align.sv
design/amo_alu.sv
design/lr_sc_reservation.sv
design/amo_sequencer.sv
design/lsu_top.sv
tb/tb_clk_gen.sv
tb/lsu_chk.sv
tb/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_pkg.sv
      - design/mem_lane_align.sv
      - design/amo_alu.sv
      - design/lr_sc_reservation.sv
      - design/amo_sequencer.sv
      - design/lsu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_clk_gen.sv
      - tb/lsu_chk.sv
      - tb/tb_lsu.sv
